//--- common/ov7670_pkg.sv
/*
  Shared constants and types for the OV7670 start-up controller.
  Modules refer to these by scoped name.
*/
`default_nettype none

package ov7670_pkg;

  // --------------------------------------------------
  // Register table
  // --------------------------------------------------
  // Table index width, 64 slots is plenty for the write list
  localparam int unsigned entry_w = 6;

  // Real writes before the end marker
  localparam logic [entry_w-1:0] num_entries = 6'd24;

  // Register address and value sent to the SCCB master
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } init_word_t;

  // No OV7670 register lives at 0xF0..0xFF, so this nibble ends the list
  localparam logic [3:0] end_nibble = 4'hF;

  // COM7 soft reset, also the first table entry
  localparam init_word_t reset_word = '{addr: 8'h12, data: 8'h80};

  // Camera write id, consumed by the SCCB master
  localparam logic [6:0] sccb_id = 7'h21;

  // --------------------------------------------------
  // Timing
  // --------------------------------------------------
  // Wide enough for 30,000,000 (300 ms at 100 MHz)
  localparam int unsigned settle_w = 25;

  // Short value for simulation
  localparam logic [settle_w-1:0] settle_cycles = 25'd40;

  // 100 MHz / 4 gives a 25 MHz camera clock
  localparam int unsigned xclk_div = 4;

  // --------------------------------------------------
  // Control FSM
  // --------------------------------------------------
  typedef enum logic [2:0] {
    st_rst_cam    = 3'd0,  // Camera held in reset
    st_wait_rst   = 3'd1,  // Camera out of reset, settling
    st_wait_ready = 3'd2,  // Waiting for the SCCB master
    st_write      = 3'd3,  // Settle after a register write
    st_done       = 3'd4   // Whole table written
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- init_seq/init_rom.sv
/*
  Combinational OV7670 register tables, normal YUV422 and colour-bar test.
  Index in, register word out, FFFF past the last entry.
*/
`timescale 1ns/1ps
`default_nettype none

module init_rom (
  input  wire logic [ov7670_pkg::entry_w-1:0] index,
  input  wire logic                           test_mode,
  output ov7670_pkg::init_word_t              word
);

  ov7670_pkg::init_word_t norm_word;
  ov7670_pkg::init_word_t test_word;

  // --------------------------------------------------
  // Normal YUV422, QQVGA/2 output
  // --------------------------------------------------
  always_comb begin
    case (index)
      6'h00: norm_word = 16'h1280;  // COM7 reset all registers
      6'h01: norm_word = 16'h1280;  // Reset twice, first may be missed
      6'h02: norm_word = 16'h1200;  // COM7 YUV output
      6'h03: norm_word = 16'h0900;  // COM2 1x drive
      6'h04: norm_word = 16'h40C0;  // COM15 full 0-255 range
      6'h05: norm_word = 16'h8C00;  // RGB444 off
      6'h06: norm_word = 16'h1180;  // CLKRC no prescale
      6'h07: norm_word = 16'h0F4B;  // COM6 reset timing on format change
      6'h08: norm_word = 16'h1E07;  // MVFP no mirror, no flip
      6'h09: norm_word = 16'h3DC0;  // COM13 gamma, UV auto adjust
      6'h0A: norm_word = 16'h1520;  // COM10 PCLK quiet in hblank
      6'h0B: norm_word = 16'h1711;  // HSTART
      6'h0C: norm_word = 16'h1800;  // HSTOP
      6'h0D: norm_word = 16'h1900;  // VSTRT
      6'h0E: norm_word = 16'h1A00;  // VSTOP
      6'h0F: norm_word = 16'h3200;  // HREF control
      6'h10: norm_word = 16'h3A04;  // TSLB line buffer, YUYV order
      6'h11: norm_word = 16'h0C04;  // COM3 scale enable
      6'h12: norm_word = 16'h3E1B;  // COM14 PCLK divide by 8
      6'h13: norm_word = 16'h703A;  // SCALING_XSC, test pattern bit 0 clear
      6'h14: norm_word = 16'h7135;  // SCALING_YSC, no test pattern
      6'h15: norm_word = 16'h7233;  // DCWCTR down sample by 8
      6'h16: norm_word = 16'h73F3;  // SCALING_PCLK_DIV by 8
      6'h17: norm_word = 16'hA202;  // SCALING_PCLK_DELAY
      default: norm_word = 16'hFFFF;  // End marker
    endcase
  end

  // --------------------------------------------------
  // Eight-bar colour test pattern
  // --------------------------------------------------
  always_comb begin
    case (index)
      6'h00: test_word = 16'h1280;
      6'h01: test_word = 16'h1280;
      6'h02: test_word = 16'h1200;
      6'h03: test_word = 16'h0900;
      6'h04: test_word = 16'h40C0;
      6'h05: test_word = 16'h8C00;
      6'h06: test_word = 16'h1180;
      6'h07: test_word = 16'h0F4B;
      6'h08: test_word = 16'h1E07;
      6'h09: test_word = 16'h3DC0;
      6'h0A: test_word = 16'h1520;
      6'h0B: test_word = 16'h1711;
      6'h0C: test_word = 16'h1800;
      6'h0D: test_word = 16'h1900;
      6'h0E: test_word = 16'h1A00;
      6'h0F: test_word = 16'h3200;
      6'h10: test_word = 16'h3A04;
      6'h11: test_word = 16'h0C04;
      6'h12: test_word = 16'h3E1B;
      6'h13: test_word = 16'h703A;
      6'h14: test_word = 16'h71B5;  // Test pattern bit 1 set, colour bars
      6'h15: test_word = 16'h7233;
      6'h16: test_word = 16'h73F3;
      6'h17: test_word = 16'hA202;
      default: test_word = 16'hFFFF;
    endcase
  end

  assign word = test_mode ? test_word : norm_word;

endmodule

`default_nettype wire

//--- init_seq/init_seq.sv
/*
  Table walker for the register writes.
  Advances on each start_tx, restarts on resend or a test_mode change.
*/
`timescale 1ns/1ps
`default_nettype none

module init_seq (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              start_tx,
  input  wire logic              resend,
  input  wire logic              test_mode,
  output ov7670_pkg::init_word_t word,
  output logic                   done
);

  logic [ov7670_pkg::entry_w-1:0] entry_cnt;
  logic                           test_mode_q;
  logic                           mode_change;
  ov7670_pkg::init_word_t         rom_word;

  init_rom rom_i (
    .index     (entry_cnt),
    .test_mode (test_mode),
    .word      (rom_word)
  );

  // Either edge of test_mode reloads the other table
  assign mode_change = test_mode ^ test_mode_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      entry_cnt   <= '0;
      test_mode_q <= 1'b0;
    end else begin
      test_mode_q <= test_mode;
      if (resend || mode_change)
        entry_cnt <= '0;
      else if (start_tx && !done)
        entry_cnt <= entry_cnt + 1'b1;
    end
  end

  // Registered ROM output, held through the write settle
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      word <= ov7670_pkg::reset_word;
    else
      word <= rom_word;
  end

  assign done = (word.addr[7:4] == ov7670_pkg::end_nibble);

  // End marker must stop the count before it runs off the table
  a_cnt_bound: assert property (@(posedge clk) disable iff (rst)
    entry_cnt <= ov7670_pkg::num_entries);

endmodule

`default_nettype wire

//--- source/settle_timer.sv
/*
  Settle period counter. Runs while enabled and strobes settle_end
  once the count reaches settle_cycles, then starts over.
*/
`timescale 1ns/1ps
`default_nettype none

module settle_timer (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic settle_en,
  output logic      settle_end
);

  logic [ov7670_pkg::settle_w-1:0] settle_cnt;

  // Count from 0, so the strobe lands settle_cycles+1 cycles after enable
  assign settle_end = settle_en && (settle_cnt == ov7670_pkg::settle_cycles);

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      settle_cnt <= '0;
    else if (!settle_en || settle_end)
      settle_cnt <= '0;
    else
      settle_cnt <= settle_cnt + 1'b1;
  end

endmodule

`default_nettype wire

//--- source/xclk_gen.sv
/*
  Camera system clock, the system clock divided by xclk_div.
  Counter MSB gives a 50% duty cycle, low first after reset.
*/
`timescale 1ns/1ps
`default_nettype none

module xclk_gen (
  input  wire logic clk,
  input  wire logic rst,
  output logic      xclk
);

  logic [$clog2(ov7670_pkg::xclk_div)-1:0] div_cnt;

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      div_cnt <= '0;
    else if (div_cnt == ov7670_pkg::xclk_div - 1)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // 0,1 low and 2,3 high
  assign xclk = div_cnt[$high(div_cnt)];

  // Each level lasts at least two system cycles
  a_xclk_hold: assert property (@(posedge clk) disable iff (rst)
    $changed(xclk) |=> $stable(xclk));

endmodule

`default_nettype wire

//--- source/init_ctrl.sv
/*
  Start-up FSM. Resets the camera, lets it settle, then issues one
  start_tx per table word with a settle period after each.
*/
`timescale 1ns/1ps
`default_nettype none

module init_ctrl (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic sccb_ready,
  input  wire logic done,
  input  wire logic settle_end,
  output logic      start_tx,
  output logic      settle_en,
  output logic      cam_rst_n
);

  ov7670_pkg::ctrl_state_e state;
  ov7670_pkg::ctrl_state_e state_nx;

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      state <= ov7670_pkg::st_rst_cam;
    else
      state <= state_nx;
  end

  // --------------------------------------------------
  // Next state and outputs
  // --------------------------------------------------
  always_comb begin
    state_nx  = state;
    start_tx  = 1'b0;
    settle_en = 1'b0;
    cam_rst_n = 1'b1;
    case (state)
      ov7670_pkg::st_rst_cam: begin
        // Camera reset held for one settle period
        cam_rst_n = 1'b0;
        settle_en = 1'b1;
        if (settle_end)
          state_nx = ov7670_pkg::st_wait_rst;
      end
      ov7670_pkg::st_wait_rst: begin
        settle_en = 1'b1;
        if (settle_end)
          state_nx = ov7670_pkg::st_wait_ready;
      end
      ov7670_pkg::st_wait_ready: begin
        // End marker takes priority over a ready master
        if (done)
          state_nx = ov7670_pkg::st_done;
        else if (sccb_ready) begin
          start_tx = 1'b1;
          state_nx = ov7670_pkg::st_write;
        end
      end
      ov7670_pkg::st_write: begin
        settle_en = 1'b1;
        if (settle_end)
          state_nx = ov7670_pkg::st_wait_ready;
      end
      ov7670_pkg::st_done: begin
        // done drops on resend or mode change, so start over with a reset
        if (!done)
          state_nx = ov7670_pkg::st_rst_cam;
      end
      default: state_nx = ov7670_pkg::st_rst_cam;
    endcase
  end

  // Only launch a write the master can accept
  a_start_ready: assert property (@(posedge clk) disable iff (rst)
    start_tx |-> sccb_ready);

  // Each write gets a full settle period, timer restarted from zero
  a_start_single: assert property (@(posedge clk) disable iff (rst)
    start_tx |=> !start_tx && !settle_end);

endmodule

`default_nettype wire

//--- source/ov7670_init.sv
/*
  OV7670 start-up controller top. Drives camera reset and xclk and
  feeds the register table to an external SCCB master.
*/
`timescale 1ns/1ps
`default_nettype none

module ov7670_init (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              test_mode,
  input  wire logic              resend,
  input  wire logic              sccb_ready,
  output logic                   start_tx,
  output ov7670_pkg::init_word_t word,
  output logic                   done,
  output logic                   cam_rst_n,
  output logic                   xclk
);

  // Settle timer handshake
  logic settle_en;
  logic settle_end;

  // --------------------------------------------------
  // Control
  // --------------------------------------------------
  init_ctrl ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .sccb_ready (sccb_ready),
    .done       (done),
    .settle_end (settle_end),
    .start_tx   (start_tx),
    .settle_en  (settle_en),
    .cam_rst_n  (cam_rst_n)
  );

  settle_timer timer_i (
    .clk        (clk),
    .rst        (rst),
    .settle_en  (settle_en),
    .settle_end (settle_end)
  );

  // --------------------------------------------------
  // Register words and camera clock
  // --------------------------------------------------
  init_seq seq_i (
    .clk       (clk),
    .rst       (rst),
    .start_tx  (start_tx),
    .resend    (resend),
    .test_mode (test_mode),
    .word      (word),
    .done      (done)
  );

  xclk_gen xclk_i (
    .clk  (clk),
    .rst  (rst),
    .xclk (xclk)
  );

endmodule

`default_nettype wire

//--- testbench/tb_ov7670_init.sv
/*
  Directed testbench for the OV7670 start-up controller.
  Acts as the SCCB master with random ready gaps and checks every word.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_ov7670_init;

  localparam int settle = int'(ov7670_pkg::settle_cycles);
  localparam int entries = int'(ov7670_pkg::num_entries);
  // One sequence with worst-case ready gaps plus both reset settles
  localparam int seq_cycles = entries * (settle + 9) + 2 * (settle + 1);
  // Four sequences, with a wide margin
  localparam int timeout_cycles = 16 * seq_cycles;

  // --------------------------------------------------
  // Expected register tables
  // --------------------------------------------------
  localparam logic [15:0] norm_table [0:23] = '{
    16'h1280, 16'h1280, 16'h1200, 16'h0900, 16'h40C0, 16'h8C00, 16'h1180, 16'h0F4B,
    16'h1E07, 16'h3DC0, 16'h1520, 16'h1711, 16'h1800, 16'h1900, 16'h1A00, 16'h3200,
    16'h3A04, 16'h0C04, 16'h3E1B, 16'h703A, 16'h7135, 16'h7233, 16'h73F3, 16'hA202
  };
  // Colour bars, only entry 0x14 differs
  localparam logic [15:0] test_table [0:23] = '{
    16'h1280, 16'h1280, 16'h1200, 16'h0900, 16'h40C0, 16'h8C00, 16'h1180, 16'h0F4B,
    16'h1E07, 16'h3DC0, 16'h1520, 16'h1711, 16'h1800, 16'h1900, 16'h1A00, 16'h3200,
    16'h3A04, 16'h0C04, 16'h3E1B, 16'h703A, 16'h71B5, 16'h7233, 16'h73F3, 16'hA202
  };

  logic clk;
  logic rst;
  logic test_mode;
  logic resend;
  logic sccb_ready;
  logic start_tx;
  ov7670_pkg::init_word_t word;
  logic done;
  logic cam_rst_n;
  logic xclk;

  int cyc = 0;
  int errors;
  int tests_run;
  int tests_failed;
  logic [15:0] lfsr;
  // Words seen at each start_tx of the current sequence
  ov7670_pkg::init_word_t captured [0:23];

  ov7670_init dut_i (
    .clk        (clk),
    .rst        (rst),
    .test_mode  (test_mode),
    .resend     (resend),
    .sccb_ready (sccb_ready),
    .start_tx   (start_tx),
    .word       (word),
    .done       (done),
    .cam_rst_n  (cam_rst_n),
    .xclk       (xclk)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == timeout_cycles) begin
      $display("Timeout, the run did not finish within %0d cycles", timeout_cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Compare and bookkeeping
  // --------------------------------------------------
  task automatic check_word(input string name, input ov7670_pkg::init_word_t exp,
                            input ov7670_pkg::init_word_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("** Error %s: expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s with %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  // start_tx follows sccb_ready within the cycle, so look mid low phase
  task automatic wait_sample();
    #10;
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Three LFSR bits give a 0..7 cycle gap
  task automatic draw_gap(output int gap);
    gap = 0;
    repeat (3) begin
      lfsr = lfsr_next(lfsr);
      gap = gap * 2 + (lfsr[0] ? 1 : 0);
    end
  endtask

  // --------------------------------------------------
  // Sequence helpers
  // --------------------------------------------------
  // Plays the master until done, checking each word against the table
  task automatic run_sequence(input string name, input logic mode, input int first);
    int k;
    int gap;
    int low_left;
    ov7670_pkg::init_word_t exp;
    k = first;
    low_left = 0;
    // Continuing right after a pulse, so the master is still busy
    if (first > 0) begin
      draw_gap(gap);
      low_left = settle + 1 + gap;
    end
    sccb_ready = (low_left == 0);
    while (!done) begin
      wait_sample();
      if (start_tx) begin
        if (k < entries) begin
          exp = mode ? test_table[k] : norm_table[k];
          captured[k] = word;
          check_word($sformatf("%s word %0d", name, k), exp, word);
        end
        k++;
        // Busy through the settle, then a random extra gap
        draw_gap(gap);
        low_left = settle + 1 + gap;
      end else if (low_left > 0) begin
        low_left--;
      end
      @(negedge clk);
      sccb_ready = (low_left == 0);
    end
    check_count({name, " pulse count"}, entries, k);
    // Ready master, but the table is finished
    sccb_ready = 1'b1;
    repeat (2 * (settle + 1)) begin
      @(negedge clk);
      check_bit({name, " start_tx after done"}, 1'b0, start_tx);
      check_bit({name, " done held"}, 1'b1, done);
    end
  endtask

  // done must fall, then the camera goes through a full reset period
  task automatic wait_restart(input string name);
    int n;
    n = 0;
    while (done && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (done) begin
      $display("%s: done stayed high after the restart request", name);
      errors++;
    end
    n = 0;
    while (cam_rst_n && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (cam_rst_n) begin
      $display("%s: camera reset was not asserted again", name);
      errors++;
    end
    n = 0;
    while (!cam_rst_n) begin
      check_bit({name, " start_tx in camera reset"}, 1'b0, start_tx);
      @(negedge clk);
      n++;
    end
    check_count({name, " camera reset length"}, settle + 1, n);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_reset();
    int e0;
    e0 = errors;
    repeat (2) @(negedge clk);
    check_bit("reset start_tx", 1'b0, start_tx);
    check_bit("reset done", 1'b0, done);
    check_bit("reset cam_rst_n", 1'b0, cam_rst_n);
    rst = 1'b0;
    // Camera reset, then settle, master kept busy throughout
    for (int i = 1; i <= 2 * (settle + 1); i++) begin
      @(negedge clk);
      check_bit("startup start_tx", 1'b0, start_tx);
      check_bit("startup done", 1'b0, done);
      check_bit($sformatf("startup cam_rst_n cycle %0d", i), i > settle, cam_rst_n);
      check_bit($sformatf("startup xclk cycle %0d", i), (i % 4) >= 2, xclk);
    end
    finish_test("reset", e0);
  endtask

  // Starts in st_wait_ready straight after the start-up settle
  task automatic test_backpressure();
    int e0;
    e0 = errors;
    repeat (100) begin
      @(negedge clk);
      check_bit("backpressure start_tx", 1'b0, start_tx);
    end
    sccb_ready = 1'b1;
    wait_sample();
    check_bit("backpressure pulse", 1'b1, start_tx);
    captured[0] = word;
    check_word("backpressure word 0", norm_table[0], word);
    // Master busy from the next falling edge
    @(negedge clk);
    sccb_ready = 1'b0;
    finish_test("backpressure", e0);
  endtask

  task automatic test_normal();
    int e0;
    e0 = errors;
    run_sequence("normal", 1'b0, 1);
    finish_test("normal", e0);
  endtask

  task automatic test_mode_switch();
    int e0;
    e0 = errors;
    test_mode = 1'b1;
    wait_restart("test_mode");
    run_sequence("test_mode", 1'b1, 0);
    check_word("test_mode entry 0x14", 16'h71B5, captured[20]);
    finish_test("test_mode", e0);
  endtask

  task automatic test_resend();
    int e0;
    e0 = errors;
    resend = 1'b1;
    @(negedge clk);
    resend = 1'b0;
    wait_restart("resend");
    run_sequence("resend", test_mode, 0);
    finish_test("resend", e0);
  endtask

  initial begin
    rst = 1'b1;
    test_mode = 1'b0;
    resend = 1'b0;
    sccb_ready = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    lfsr = 16'd26604;
    test_reset();
    test_backpressure();
    test_normal();
    test_mode_switch();
    test_resend();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ov7670_init.f
common/ov7670_pkg.sv
init_seq/init_rom.sv
init_seq/init_seq.sv
source/settle_timer.sv
source/xclk_gen.sv
source/init_ctrl.sv
source/ov7670_init.sv
testbench/tb_ov7670_init.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the OV7670 start-up controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ov7670_init -f ov7670_init.f -o tb_ov7670_init
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_ov7670_init > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
